// ==== tx_sched_config.svh ====
// Transmit scheduler sizing constants shared by the package and the RTL
`ifndef TX_SCHED_CONFIG_SVH
`define TX_SCHED_CONFIG_SVH

// Queue set, index width must cover the count
`define TX_SCHED_QUEUE_COUNT 16
`define TX_SCHED_QUEUE_WIDTH 4

// Outstanding transmit operations
`define TX_SCHED_TAG_WIDTH 3
`define TX_SCHED_OP_TABLE_SIZE 8

// Status length field
`define TX_SCHED_LEN_WIDTH 16

// Destination carried on each request
`define TX_SCHED_DEST_WIDTH 8

`endif

// ==== tx_sched_pkg.sv ====
// Transmit scheduler types for requests, status, doorbells and register access
`default_nettype none

`include "tx_sched_config.svh"

package tx_sched_pkg;

    // Transmit request towards the packet engine
    typedef struct packed {
        logic [`TX_SCHED_QUEUE_WIDTH-1:0] queue;
        logic [`TX_SCHED_TAG_WIDTH-1:0]   tag;
        logic [`TX_SCHED_DEST_WIDTH-1:0]  dest;
    } tx_req_t;

    // Completion for one tag, zero length means the queue had nothing
    typedef struct packed {
        logic [`TX_SCHED_LEN_WIDTH-1:0] len;
        logic [`TX_SCHED_TAG_WIDTH-1:0] tag;
    } tx_status_t;

    typedef struct packed {
        logic [`TX_SCHED_QUEUE_WIDTH-1:0] queue;
    } tx_doorbell_t;

    // Register write, en held until ack
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
        logic        en;
    } reg_wr_t;

    typedef struct packed {
        logic [7:0] addr;
        logic       en;
    } reg_rd_t;

endpackage

`default_nettype wire

// ==== tx_sched_regs.sv ====
// Control registers for the transmit scheduler: enable, destination and ID words
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_regs (
    input  wire                               clk,
    input  wire                               rst,

    input  wire tx_sched_pkg::reg_wr_t        reg_wr,
    output logic                              wr_ack,
    input  wire tx_sched_pkg::reg_rd_t        reg_rd,
    output logic [31:0]                       rd_data,
    output logic                              rd_ack,

    output logic                              enable,
    output logic [`TX_SCHED_DEST_WIDTH-1:0]   dest
);

    import tx_sched_pkg::*;

    localparam logic [31:0] BLOCK_TYPE    = 32'h0000C004;
    localparam logic [31:0] BLOCK_VERSION = 32'h00000100;

    // Word aligned offsets
    logic [7:0] wr_addr;
    logic [7:0] rd_addr;

    assign wr_addr = {reg_wr.addr[7:2], 2'b00};
    assign rd_addr = {reg_rd.addr[7:2], 2'b00};

    always_ff @(posedge clk) begin
        wr_ack <= 1'b0;
        rd_ack <= 1'b0;

        // Skip the ack cycle so a held en is taken once
        if (reg_wr.en && !wr_ack) begin
            case (wr_addr)
                8'h00, 8'h04, 8'h08: begin
                    // ID words, write is dropped
                    wr_ack <= 1'b1;
                end
                8'h0C: begin
                    enable <= reg_wr.data[0];
                    wr_ack <= 1'b1;
                end
                8'h10: begin
                    dest   <= reg_wr.data[`TX_SCHED_DEST_WIDTH-1:0];
                    wr_ack <= 1'b1;
                end
                default: begin
                    wr_ack <= 1'b0;
                end
            endcase
        end

        if (reg_rd.en && !rd_ack) begin
            rd_ack <= 1'b1;
            case (rd_addr)
                8'h00:   rd_data <= BLOCK_TYPE;
                8'h04:   rd_data <= BLOCK_VERSION;
                8'h08:   rd_data <= 32'(`TX_SCHED_QUEUE_COUNT);
                8'h0C:   rd_data <= {31'd0, enable};
                8'h10:   rd_data <= 32'(dest);
                // Unmapped, master waits forever
                default: rd_ack <= 1'b0;
            endcase
        end

        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
            enable <= 1'b0;
            dest   <= '0;
        end
    end

    // One ack per access even while en stays high across the ack cycle
    assert property (@(posedge clk) disable iff (rst) wr_ack |=> !wr_ack);
    assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack);

endmodule

`default_nettype wire

// ==== tx_sched_queue_state.sv ====
// Per-queue pending and in-flight tracking, producing the eligible queue vector
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_queue_state (
    input  wire                                clk,
    input  wire                                rst,

    input  wire tx_sched_pkg::tx_doorbell_t    doorbell,
    input  wire                                doorbell_valid,

    input  wire                                grant_valid,
    input  wire [`TX_SCHED_QUEUE_WIDTH-1:0]    grant_queue,

    input  wire                                retire_valid,
    input  wire [`TX_SCHED_QUEUE_WIDTH-1:0]    retire_queue,
    input  wire                                retire_empty,

    output logic [`TX_SCHED_QUEUE_COUNT-1:0]   eligible
);

    import tx_sched_pkg::*;

    localparam int QUEUE_COUNT = `TX_SCHED_QUEUE_COUNT;

    logic [QUEUE_COUNT-1:0] pending;
    logic [QUEUE_COUNT-1:0] in_flight;
    // Doorbell seen while the queue had a request out
    logic [QUEUE_COUNT-1:0] rung;

    logic [QUEUE_COUNT-1:0] doorbell_hit;
    logic [QUEUE_COUNT-1:0] grant_hit;
    logic [QUEUE_COUNT-1:0] retire_hit;
    logic [QUEUE_COUNT-1:0] empty_clear;

    always_comb begin
        doorbell_hit = '0;
        grant_hit    = '0;
        retire_hit   = '0;
        doorbell_hit[doorbell.queue] = doorbell_valid;
        grant_hit[grant_queue]       = grant_valid;
        retire_hit[retire_queue]     = retire_valid;
    end

    // Empty status drops pending unless the host rang again meanwhile
    assign empty_clear = retire_hit & {QUEUE_COUNT{retire_empty}} & ~rung;

    assign eligible = pending & ~in_flight;

    always_ff @(posedge clk) begin
        // A doorbell in the retire cycle still wins
        pending   <= (pending & ~empty_clear) | doorbell_hit;
        in_flight <= (in_flight & ~retire_hit) | grant_hit;
        rung      <= (rung | (doorbell_hit & in_flight)) & ~retire_hit & ~grant_hit;

        if (rst) begin
            pending   <= '0;
            in_flight <= '0;
            rung      <= '0;
        end
    end

    // Issuer and op table must never double-book a queue
    assert property (@(posedge clk) disable iff (rst)
        grant_valid |-> !in_flight[grant_queue]);

endmodule

`default_nettype wire

// ==== tx_sched_op_table.sv ====
// Operation table: tag allocation and tag-to-queue lookup for retiring status
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_op_table (
    input  wire                               clk,
    input  wire                               rst,

    input  wire                               alloc_valid,
    input  wire [`TX_SCHED_QUEUE_WIDTH-1:0]   alloc_queue,
    output logic [`TX_SCHED_TAG_WIDTH-1:0]    free_tag,
    output logic                              tag_avail,

    input  wire tx_sched_pkg::tx_status_t     status,
    input  wire                               status_valid,

    output logic                              retire_valid,
    output logic [`TX_SCHED_QUEUE_WIDTH-1:0]  retire_queue,
    output logic                              retire_empty
);

    import tx_sched_pkg::*;

    localparam int TABLE_SIZE = `TX_SCHED_OP_TABLE_SIZE;
    localparam int TW = `TX_SCHED_TAG_WIDTH;

    logic [TABLE_SIZE-1:0] busy;
    logic [TABLE_SIZE-1:0] busy_next;
    logic [`TX_SCHED_QUEUE_WIDTH-1:0] queue_mem [TABLE_SIZE];
    logic [TW-1:0] lowest_free;
    logic any_free;

    always_comb begin
        busy_next = busy;
        if (status_valid) begin
            busy_next[status.tag] = 1'b0;
        end
        if (alloc_valid) begin
            busy_next[free_tag] = 1'b1;
        end
    end

    // Priority pick, lowest index wins
    always_comb begin
        lowest_free = '0;
        any_free    = 1'b0;
        for (int t = TABLE_SIZE - 1; t >= 0; t--) begin
            if (!busy_next[t]) begin
                lowest_free = TW'(t);
                any_free    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        busy <= busy_next;
        // Offered tag is held until taken, the issuer may have latched it
        if (alloc_valid || !tag_avail) begin
            free_tag  <= lowest_free;
            tag_avail <= any_free;
        end

        if (rst) begin
            busy      <= '0;
            free_tag  <= '0;
            tag_avail <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            queue_mem[free_tag] <= alloc_queue;
        end
    end

    assign retire_valid = status_valid;
    assign retire_queue = queue_mem[status.tag];
    assign retire_empty = (status.len == '0);

    // Status only for tags handed out earlier
    assert property (@(posedge clk) disable iff (rst)
        status_valid |-> busy[status.tag]);

endmodule

`default_nettype wire

// ==== tx_sched_rr.sv ====
// Round-robin issuer: picks the next eligible queue and drives the request port
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_rr (
    input  wire                               clk,
    input  wire                               rst,

    input  wire                               enable,
    input  wire [`TX_SCHED_DEST_WIDTH-1:0]    dest,
    input  wire [`TX_SCHED_QUEUE_COUNT-1:0]   eligible,
    input  wire                               tag_avail,
    input  wire [`TX_SCHED_TAG_WIDTH-1:0]     free_tag,

    output tx_sched_pkg::tx_req_t             req,
    output logic                              req_valid,
    input  wire                               req_ready,

    output logic                              grant_valid,
    output logic [`TX_SCHED_QUEUE_WIDTH-1:0]  grant_queue
);

    import tx_sched_pkg::*;

    localparam int QUEUE_COUNT = `TX_SCHED_QUEUE_COUNT;
    localparam int QW = `TX_SCHED_QUEUE_WIDTH;

    // Queue granted most recently, search starts just after it
    logic [QW-1:0] last_queue;
    logic [QW-1:0] pick_queue;
    logic pick_found;
    logic start;

    // Wrapping scan over all queues from last_queue + 1
    always_comb begin
        int probe;
        pick_found = 1'b0;
        pick_queue = '0;
        for (int i = 1; i <= QUEUE_COUNT; i++) begin
            probe = (int'(last_queue) + i) % QUEUE_COUNT;
            if (!pick_found && eligible[probe]) begin
                pick_found = 1'b1;
                pick_queue = QW'(probe);
            end
        end
    end

    // Only from idle, so eligible already reflects the last grant
    assign start = !req_valid && enable && tag_avail && pick_found;

    assign grant_valid = req_valid && req_ready;
    assign grant_queue = req.queue;

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            req_valid  <= 1'b0;
            last_queue <= req.queue;
        end else if (start) begin
            req_valid <= 1'b1;
        end

        if (rst) begin
            req_valid  <= 1'b0;
            last_queue <= QW'(QUEUE_COUNT - 1);
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (start) begin
            req.queue <= pick_queue;
            req.tag   <= free_tag;
            req.dest  <= dest;
        end
    end

    // Stalled request keeps valid and payload until the handshake
    assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

// ==== tx_sched_block.sv ====
// Transmit scheduler top: registers, queue state, op table and round-robin issuer
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_block (
    input  wire                              clk,
    input  wire                              rst,

    input  wire tx_sched_pkg::reg_wr_t       reg_wr,
    output logic                             wr_ack,
    input  wire tx_sched_pkg::reg_rd_t       reg_rd,
    output logic [31:0]                      rd_data,
    output logic                             rd_ack,

    input  wire tx_sched_pkg::tx_doorbell_t  doorbell,
    input  wire                              doorbell_valid,

    output tx_sched_pkg::tx_req_t            req,
    output logic                             req_valid,
    input  wire                              req_ready,

    input  wire tx_sched_pkg::tx_status_t    status,
    input  wire                              status_valid
);

    import tx_sched_pkg::*;

    logic                              enable;
    logic [`TX_SCHED_DEST_WIDTH-1:0]   dest;
    logic [`TX_SCHED_QUEUE_COUNT-1:0]  eligible;
    logic                              grant_valid;
    logic [`TX_SCHED_QUEUE_WIDTH-1:0]  grant_queue;
    logic [`TX_SCHED_TAG_WIDTH-1:0]    free_tag;
    logic                              tag_avail;
    logic                              retire_valid;
    logic [`TX_SCHED_QUEUE_WIDTH-1:0]  retire_queue;
    logic                              retire_empty;

    tx_sched_regs regs_i (
        .clk     (clk),
        .rst     (rst),
        .reg_wr  (reg_wr),
        .wr_ack  (wr_ack),
        .reg_rd  (reg_rd),
        .rd_data (rd_data),
        .rd_ack  (rd_ack),
        .enable  (enable),
        .dest    (dest)
    );

    tx_sched_queue_state queue_state_i (
        .clk            (clk),
        .rst            (rst),
        .doorbell       (doorbell),
        .doorbell_valid (doorbell_valid),
        .grant_valid    (grant_valid),
        .grant_queue    (grant_queue),
        .retire_valid   (retire_valid),
        .retire_queue   (retire_queue),
        .retire_empty   (retire_empty),
        .eligible       (eligible)
    );

    // Allocation happens on request acceptance
    tx_sched_op_table op_table_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (grant_valid),
        .alloc_queue  (grant_queue),
        .free_tag     (free_tag),
        .tag_avail    (tag_avail),
        .status       (status),
        .status_valid (status_valid),
        .retire_valid (retire_valid),
        .retire_queue (retire_queue),
        .retire_empty (retire_empty)
    );

    tx_sched_rr rr_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .dest        (dest),
        .eligible    (eligible),
        .tag_avail   (tag_avail),
        .free_tag    (free_tag),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .grant_valid (grant_valid),
        .grant_queue (grant_queue)
    );

endmodule

`default_nettype wire

// ==== tx_sched_checker.sv ====
// Transmit scheduler checker: reference model of queue and tag state, compares DUT responses
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tx_sched_checker (
    input  wire                              clk,
    input  wire                              rst,
    input  wire tx_sched_pkg::reg_wr_t       reg_wr,
    input  wire                              wr_ack,
    input  wire tx_sched_pkg::reg_rd_t       reg_rd,
    input  wire [31:0]                       rd_data,
    input  wire                              rd_ack,
    input  wire tx_sched_pkg::tx_doorbell_t  doorbell,
    input  wire                              doorbell_valid,
    input  wire tx_sched_pkg::tx_req_t       req,
    input  wire                              req_valid,
    input  wire                              req_ready,
    input  wire tx_sched_pkg::tx_status_t    status,
    input  wire                              status_valid,
    output int                               error_count,
    output int                               grant_count
);

    import tx_sched_pkg::*;

    localparam int QUEUES = `TX_SCHED_QUEUE_COUNT;
    localparam int TAGS   = `TX_SCHED_OP_TABLE_SIZE;

    bit pending [QUEUES];
    bit in_flight [QUEUES];
    // Host rang again while the queue had a request out
    bit rung [QUEUES];
    bit tag_busy [TAGS];
    int tag_queue [TAGS];
    bit model_enable;
    logic [`TX_SCHED_DEST_WIDTH-1:0] model_dest;
    tx_req_t grant_log [$];
    tx_req_t last_req;
    bit last_stall;
    bit last_valid;
    // Eligibility and last grant as the issuer saw them one edge back
    bit elig_snap [QUEUES];
    int last_grant;
    int last_grant_snap;

    task automatic report(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        error_count++;
    endtask

    function automatic bit is_mapped(input logic [7:0] addr);
        return addr[7:2] <= 6'd4;
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        case ({addr[7:2], 2'b00})
            8'h00:   return 32'h0000C004;
            8'h04:   return 32'h00000100;
            8'h08:   return 32'(QUEUES);
            8'h0C:   return {31'd0, model_enable};
            8'h10:   return 32'(model_dest);
            default: return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        int q;
        int r;
        int pick_q;
        int probe;
        if (rst) begin
            foreach (pending[i]) begin
                pending[i]   = 1'b0;
                in_flight[i] = 1'b0;
                rung[i]      = 1'b0;
                elig_snap[i] = 1'b0;
            end
            foreach (tag_busy[i]) tag_busy[i] = 1'b0;
            model_enable    = 1'b0;
            model_dest      = '0;
            last_stall      = 1'b0;
            last_valid      = 1'b0;
            last_grant      = QUEUES - 1;
            last_grant_snap = QUEUES - 1;
            error_count     = 0;
            grant_count     = 0;
            grant_log.delete();
        end else begin
            // New request was picked at the previous edge from the snapshot
            if (req_valid && !last_valid) begin
                pick_q = -1;
                for (int i = 1; i <= QUEUES; i++) begin
                    probe = (last_grant_snap + i) % QUEUES;
                    if (pick_q < 0 && elig_snap[probe]) begin
                        pick_q = probe;
                    end
                end
                if (pick_q < 0) begin
                    report("request raised with no eligible queue");
                end else if (int'(req.queue) != pick_q) begin
                    report($sformatf("request for queue %0d, round-robin expects %0d",
                        req.queue, pick_q));
                end
            end
            foreach (elig_snap[i]) begin
                elig_snap[i] = pending[i] && !in_flight[i];
            end
            last_grant_snap = last_grant;

            if (wr_ack) begin
                if (!is_mapped(reg_wr.addr)) begin
                    report($sformatf("write ack for unmapped address 0x%02h", reg_wr.addr));
                end else if (reg_wr.addr[7:2] == 6'h03) begin
                    model_enable = reg_wr.data[0];
                end else if (reg_wr.addr[7:2] == 6'h04) begin
                    model_dest = reg_wr.data[`TX_SCHED_DEST_WIDTH-1:0];
                end
            end
            if (rd_ack) begin
                if (!is_mapped(reg_rd.addr)) begin
                    report($sformatf("read ack for unmapped address 0x%02h", reg_rd.addr));
                end else if (rd_data !== expected_read(reg_rd.addr)) begin
                    report($sformatf("read 0x%02h returned %08h, expected %08h",
                        reg_rd.addr, rd_data, expected_read(reg_rd.addr)));
                end
            end

            if (last_stall && (!req_valid || req !== last_req)) begin
                report("request dropped or changed while stalled");
            end
            if (req_valid && !last_valid && !model_enable) begin
                report("request raised while disabled");
            end
            // Eligibility is judged on the state before this edge
            q = int'(req.queue);
            if (req_valid && req_ready) begin
                if (!pending[q] || in_flight[q]) begin
                    report($sformatf("request for queue %0d which is not eligible", q));
                end
                if (tag_busy[req.tag]) begin
                    report($sformatf("request uses tag %0d which is in flight", req.tag));
                end
                if (req.dest !== model_dest) begin
                    report($sformatf("request dest %02h, expected %02h", req.dest, model_dest));
                end
            end

            if (status_valid) begin
                if (!tag_busy[status.tag]) begin
                    report($sformatf("status for free tag %0d", status.tag));
                end else begin
                    r = tag_queue[status.tag];
                    in_flight[r] = 1'b0;
                    if (status.len == '0 && !rung[r]) begin
                        pending[r] = 1'b0;
                    end
                    rung[r] = 1'b0;
                    tag_busy[status.tag] = 1'b0;
                end
            end
            if (doorbell_valid) begin
                if (in_flight[doorbell.queue]) begin
                    rung[doorbell.queue] = 1'b1;
                end
                pending[doorbell.queue] = 1'b1;
            end
            if (req_valid && req_ready) begin
                in_flight[q] = 1'b1;
                rung[q]      = 1'b0;
                tag_busy[req.tag]  = 1'b1;
                tag_queue[req.tag] = q;
                last_grant = q;
                grant_log.push_back(req);
                grant_count++;
            end

            last_stall = req_valid && !req_ready;
            last_valid = req_valid;
            last_req   = req;
        end
    end

    task automatic check_grant_total(input int expected);
        if (grant_count != expected) begin
            report($sformatf("%0d requests seen, expected %0d", grant_count, expected));
        end
    endtask

    task automatic check_order(input int a, input int b, input int c, input int d);
        int exp_q [4];
        int first;
        exp_q = '{a, b, c, d};
        first = grant_log.size() - 4;
        if (first < 0) begin
            report("fewer than four requests logged");
            return;
        end
        for (int i = 0; i < 4; i++) begin
            if (int'(grant_log[first + i].queue) != exp_q[i]) begin
                report($sformatf("request %0d went to queue %0d, expected %0d",
                    i, grant_log[first + i].queue, exp_q[i]));
            end
        end
    endtask

    // Last n requests must all carry different tags
    task automatic check_distinct_tags(input int n);
        bit seen [TAGS];
        int first;
        first = grant_log.size() - n;
        foreach (seen[i]) seen[i] = 1'b0;
        for (int i = (first < 0) ? 0 : first; i < grant_log.size(); i++) begin
            if (seen[grant_log[i].tag]) begin
                report($sformatf("tag %0d issued twice", grant_log[i].tag));
            end
            seen[grant_log[i].tag] = 1'b1;
        end
    endtask

endmodule

`default_nettype wire

// ==== tb_tx_sched.sv ====
// Transmit scheduler testbench with directed tests and seeded random traffic
`timescale 1ns/10ps
`default_nettype none

`include "tx_sched_config.svh"

module tb_tx_sched;

    import tx_sched_pkg::*;

    // Cycle budget of each test in turn, run limit adds 20 percent
    localparam int BUDGET        = 60 + 60 + 80 + 120 + 2000;
    localparam int LIMIT         = BUDGET * 12 / 10;
    localparam int RANDOM_CYCLES = 2000;
    localparam int QUEUES        = `TX_SCHED_QUEUE_COUNT;
    localparam int QW            = `TX_SCHED_QUEUE_WIDTH;

    logic         clk;
    logic         rst;
    reg_wr_t      reg_wr;
    logic         wr_ack;
    reg_rd_t      reg_rd;
    logic [31:0]  rd_data;
    logic         rd_ack;
    tx_doorbell_t doorbell;
    logic         doorbell_valid;
    tx_req_t      req;
    logic         req_valid;
    logic         req_ready;
    tx_status_t   status;
    logic         status_valid;
    int           error_count;
    int           grant_count;

    int cycle_count;
    int issues;
    int tests_run;
    int tests_failed;
    int mark;
    int base;
    int hold;
    int pick;
    logic [`TX_SCHED_TAG_WIDTH-1:0] ret_tag;
    // Tags accepted downstream and not yet answered with status
    logic [`TX_SCHED_TAG_WIDTH-1:0] seen_tags [$];

    tx_sched_block tx_sched_block_i (
        .clk(clk), .rst(rst),
        .reg_wr(reg_wr), .wr_ack(wr_ack),
        .reg_rd(reg_rd), .rd_data(rd_data), .rd_ack(rd_ack),
        .doorbell(doorbell), .doorbell_valid(doorbell_valid),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .status(status), .status_valid(status_valid)
    );

    tx_sched_checker checker_i (
        .clk(clk), .rst(rst),
        .reg_wr(reg_wr), .wr_ack(wr_ack),
        .reg_rd(reg_rd), .rd_data(rd_data), .rd_ack(rd_ack),
        .doorbell(doorbell), .doorbell_valid(doorbell_valid),
        .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .status(status), .status_valid(status_valid),
        .error_count(error_count), .grant_count(grant_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && req_valid && req_ready) begin
            seen_tags.push_back(req.tag);
        end
    end

    // Advance one clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int n;
        reg_wr.addr = addr;
        reg_wr.data = data;
        reg_wr.en   = 1'b1;
        n = 0;
        do begin
            step();
            n++;
        end while (!wr_ack && n < 8);
        if (!wr_ack) begin
            $display("No ack for register write at 0x%02h", addr);
            issues++;
        end else if (n != 1) begin
            $display("Register write at 0x%02h acked after %0d cycles instead of 1", addr, n);
            issues++;
        end
        reg_wr.en = 1'b0;
        step();
    endtask

    task automatic read_reg(input logic [7:0] addr);
        int n;
        reg_rd.addr = addr;
        reg_rd.en   = 1'b1;
        n = 0;
        do begin
            step();
            n++;
        end while (!rd_ack && n < 8);
        if (!rd_ack) begin
            $display("No ack for register read at 0x%02h", addr);
            issues++;
        end else if (n != 1) begin
            $display("Register read at 0x%02h acked after %0d cycles instead of 1", addr, n);
            issues++;
        end
        reg_rd.en = 1'b0;
        step();
    endtask

    // Unmapped read, any ack is flagged by the checker
    task automatic probe_unmapped(input logic [7:0] addr);
        reg_rd.addr = addr;
        reg_rd.en   = 1'b1;
        idle(4);
        reg_rd.en = 1'b0;
        step();
    endtask

    task automatic ring(input logic [QW-1:0] q);
        doorbell.queue = q;
        doorbell_valid = 1'b1;
        step();
        doorbell_valid = 1'b0;
    endtask

    task automatic send_status(input logic [`TX_SCHED_TAG_WIDTH-1:0] tag,
                               input logic [`TX_SCHED_LEN_WIDTH-1:0] len);
        status.tag   = tag;
        status.len   = len;
        status_valid = 1'b1;
        step();
        status_valid = 1'b0;
    endtask

    task automatic wait_grants(input int target, input int max_cycles, input string what);
        int n;
        n = 0;
        while (grant_count < target && n < max_cycles) begin
            step();
            n++;
        end
        if (grant_count < target) begin
            $display("Timed out waiting for %s", what);
            issues++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count + issues != mark) begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end else begin
            $display("Test %0d %s: passed", tests_run, name);
        end
        mark = error_count + issues;
    endtask

    initial begin
        void'($urandom(88));
        rst            = 1'b1;
        reg_wr         = '0;
        reg_rd         = '0;
        doorbell       = '0;
        doorbell_valid = 1'b0;
        req_ready      = 1'b0;
        status         = '0;
        status_valid   = 1'b0;
        cycle_count    = 0;
        issues         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        mark           = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        step();

        read_reg(8'h00);
        read_reg(8'h04);
        read_reg(8'h08);
        read_reg(8'h0C);
        read_reg(8'h10);
        probe_unmapped(8'h20);
        finish_test("registers after reset");

        write_reg(8'h10, 32'h0000005A);
        read_reg(8'h10);
        // No queue is pending yet, so a short enable issues nothing
        write_reg(8'h0C, 32'h00000001);
        read_reg(8'h0C);
        write_reg(8'h0C, 32'h00000000);
        read_reg(8'h0C);
        ring(4'd3);
        ring(4'd9);
        idle(20);
        checker_i.check_grant_total(0);
        finish_test("register writes");

        req_ready = 1'b1;
        ring(4'd3);
        ring(4'd7);
        ring(4'd9);
        ring(4'd12);
        write_reg(8'h0C, 32'h00000001);
        read_reg(8'h0C);
        wait_grants(4, 40, "four round-robin requests");
        idle(5);
        checker_i.check_grant_total(4);
        checker_i.check_order(3, 7, 9, 12);
        checker_i.check_distinct_tags(4);
        // Empty status with no new doorbells leaves all four idle
        while (seen_tags.size() > 0) begin
            ret_tag = seen_tags.pop_front();
            send_status(ret_tag, 16'd0);
        end
        idle(10);
        checker_i.check_grant_total(4);
        finish_test("round-robin order");

        base = grant_count;
        for (int q = 0; q < QUEUES; q++) begin
            ring(QW'(q));
        end
        wait_grants(base + 8, 60, "eight requests");
        idle(20);
        checker_i.check_grant_total(base + 8);
        checker_i.check_distinct_tags(8);
        ret_tag = seen_tags.pop_front();
        send_status(ret_tag, 16'd64);
        wait_grants(base + 9, 20, "a request after one freed tag");
        idle(10);
        checker_i.check_grant_total(base + 9);
        finish_test("tag exhaustion");

        hold = 0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            doorbell_valid = ($urandom % 4) == 0;
            doorbell.queue = QW'($urandom % QUEUES);
            req_ready      = ($urandom % 4) != 0;
            status_valid   = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if (seen_tags.size() > 0) begin
                pick = int'($urandom % seen_tags.size());
                status.tag = seen_tags[pick];
                seen_tags.delete(pick);
                status.len = (($urandom % 2) == 0) ? 16'd0 : 16'(1 + $urandom % 1500);
                status_valid = 1'b1;
                hold = int'($urandom % 6);
            end
            step();
        end
        doorbell_valid = 1'b0;
        status_valid   = 1'b0;
        req_ready      = 1'b1;
        idle(5);
        finish_test("random traffic");

        $display("Summary: %0d tests, %0d failed, %0d value errors, %0d other failures",
            tests_run, tests_failed, error_count, issues);
        if (tests_failed == 0 && error_count == 0 && issues == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
tx_sched_pkg.sv
tx_sched_regs.sv
tx_sched_queue_state.sv
tx_sched_op_table.sv
tx_sched_rr.sv
tx_sched_block.sv
tx_sched_checker.sv
tb_tx_sched.sv

// ==== Makefile ====
# Verilator build and run of the transmit scheduler testbench

SIM = obj_dir/tb_tx_sched

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tx_sched \
		-f sources.f -Mdir obj_dir -o tb_tx_sched
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
